/* filelist.f */
logic/mipsPkg.sv
logic/decodeIf.sv
logic/mainDecoder.sv
logic/aluDecoder.sv
logic/ctrlPipe.sv
logic/controlUnit.sv
tb/controlUnitTb.sv

/* logic/aluDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module aluDecoder (
    decodeIf.alu dec
);
    import mipsPkg::*;

    opT    op;
    functT funct;
    regT   rt;

    assign op    = dec.instr[31:26];
    assign funct = dec.instr[5:0];
    assign rt    = dec.instr[20:16];

    always_comb begin
        dec.aluCtrl = ALU_NOP;
        case (op)
            OP_R_TYPE: begin
                case (funct)
                    FUN_ADD, FUN_ADDU: dec.aluCtrl = ALU_ADD;
                    FUN_SUB, FUN_SUBU: dec.aluCtrl = ALU_SUB;
                    FUN_AND:           dec.aluCtrl = ALU_AND;
                    FUN_OR:            dec.aluCtrl = ALU_OR;
                    FUN_XOR:           dec.aluCtrl = ALU_XOR;
                    FUN_NOR:           dec.aluCtrl = ALU_NOR;
                    FUN_SLT:           dec.aluCtrl = ALU_SLT;
                    FUN_SLTU:          dec.aluCtrl = ALU_SLTU;
                    FUN_SLL, FUN_SLLV: dec.aluCtrl = ALU_SLL; // variable forms share the op
                    FUN_SRL, FUN_SRLV: dec.aluCtrl = ALU_SRL;
                    FUN_SRA, FUN_SRAV: dec.aluCtrl = ALU_SRA;
                    // mult, div, hi/lo moves and jumps
                    default:           dec.aluCtrl = ALU_NOP;
                endcase
            end
            OP_ADDI, OP_ADDIU: dec.aluCtrl = ALU_ADD;
            OP_SLTI:           dec.aluCtrl = ALU_SLT;
            OP_SLTIU:          dec.aluCtrl = ALU_SLTU;
            OP_ANDI:           dec.aluCtrl = ALU_AND;
            OP_ORI:            dec.aluCtrl = ALU_OR;
            OP_XORI:           dec.aluCtrl = ALU_XOR;
            OP_LUI:            dec.aluCtrl = ALU_LUI;

            // address calculation
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW,
            OP_SB, OP_SH, OP_SW: dec.aluCtrl = ALU_ADD;

            OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ: dec.aluCtrl = ALU_SUB;
            OP_REGIMM: begin
                case (rt)
                    RT_BGEZ, RT_BLTZ,
                    RT_BGEZAL, RT_BLTZAL: dec.aluCtrl = ALU_SUB;
                    default:              dec.aluCtrl = ALU_NOP; // unknown rt
                endcase
            end
            default: dec.aluCtrl = ALU_NOP;
        endcase
    end

endmodule

`default_nettype wire

/* logic/controlUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input  wire               clk,
    input  wire               rstN,
    input  wire               flushE,
    input  wire               stallE,
    input  mipsPkg::instrT    instrD,
    output wire               regWriteE,
    output wire               regWriteM,
    output wire               regWriteW,
    output wire               regDstE,
    output wire               aluSrcAE,
    output wire               aluSrcBE,
    output wire               memWriteM,
    output wire               memToRegE,
    output wire               memToRegM,
    output wire               memToRegW,
    output wire               hiloWriteM,
    output wire               branchD,
    output wire               jumpD,
    output wire               balD,
    output wire               balE,
    output wire               balW,
    output wire               jalD,
    output wire               jalE,
    output wire               jalW,
    output wire               jrD,
    output wire               jrE,
    output wire               jrW,
    output wire               memEnD,
    output mipsPkg::aluCtrlT  aluCtrlE
);
    import mipsPkg::*;

    ctrlT ctrlE;
    ctrlT ctrlM;
    ctrlT ctrlW;

    decodeIf dec ();

    assign dec.instr = instrD;

    mainDecoder i_mainDecoder (.dec(dec.main));
    aluDecoder  i_aluDecoder  (.dec(dec.alu));

    ctrlPipe i_ctrlPipe (
        .clk      (clk),
        .rstN     (rstN),
        .flushE   (flushE),
        .stallE   (stallE),
        .dec      (dec.pipe),
        .ctrlE    (ctrlE),
        .ctrlM    (ctrlM),
        .ctrlW    (ctrlW),
        .aluCtrlE (aluCtrlE)
    );

    // decode stage, straight from the decoder
    assign branchD = dec.ctrl[CB_BRANCH];
    assign jumpD   = dec.ctrl[CB_JUMP];
    assign balD    = dec.ctrl[CB_BAL];
    assign jalD    = dec.ctrl[CB_JAL];
    assign jrD     = dec.ctrl[CB_JR];
    assign memEnD  = dec.memEn;

    assign regWriteE = ctrlE[CB_REG_WRITE];
    assign regDstE   = ctrlE[CB_REG_DST];
    assign aluSrcAE  = ctrlE[CB_ALU_SRC_A];
    assign aluSrcBE  = ctrlE[CB_ALU_SRC_B];
    assign memToRegE = ctrlE[CB_MEM_TO_REG];
    assign balE      = ctrlE[CB_BAL];
    assign jalE      = ctrlE[CB_JAL];
    assign jrE       = ctrlE[CB_JR];

    assign regWriteM  = ctrlM[CB_REG_WRITE];
    assign memWriteM  = ctrlM[CB_MEM_WRITE];
    assign memToRegM  = ctrlM[CB_MEM_TO_REG];
    assign hiloWriteM = ctrlM[CB_HILO_WRITE];

    assign regWriteW = ctrlW[CB_REG_WRITE];
    assign memToRegW = ctrlW[CB_MEM_TO_REG];
    assign balW      = ctrlW[CB_BAL]; // link writes in writeback
    assign jalW      = ctrlW[CB_JAL];
    assign jrW       = ctrlW[CB_JR];

endmodule

`default_nettype wire

/* logic/ctrlPipe.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrlPipe (
    input  wire               clk,
    input  wire               rstN,
    input  wire               flushE,
    input  wire               stallE,
    decodeIf.pipe             dec,
    output mipsPkg::ctrlT     ctrlE,
    output mipsPkg::ctrlT     ctrlM,
    output mipsPkg::ctrlT     ctrlW,
    output mipsPkg::aluCtrlT  aluCtrlE
);
    import mipsPkg::*;

    // execute stage, flush before stall
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ctrlE    <= '0;
            aluCtrlE <= '0;
        end else if (flushE) begin
            ctrlE    <= '0; // bubble
            aluCtrlE <= '0;
        end else if (!stallE) begin
            ctrlE    <= dec.ctrl;
            aluCtrlE <= dec.aluCtrl;
        end
    end

    // memory stage loads every cycle, a held E word goes through again
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ctrlM <= '0;
        end else begin
            ctrlM <= ctrlE;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ctrlW <= '0;
        end else begin
            ctrlW <= ctrlM; // writeback
        end
    end

endmodule

`default_nettype wire

/* logic/decodeIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface decodeIf;
    import mipsPkg::*;

    instrT   instr;   // decode stage instruction
    ctrlT    ctrl;
    logic    memEn;
    aluCtrlT aluCtrl;

    modport main (
        input  instr,
        output ctrl,
        output memEn
    );

    modport alu (
        input  instr,
        output aluCtrl
    );

    modport pipe (
        input ctrl,
        input aluCtrl
    );

endinterface

`default_nettype wire

/* logic/mainDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module mainDecoder (
    decodeIf.main dec
);
    import mipsPkg::*;

    // control words used by more than one instruction
    localparam ctrlT CW_NONE   = '0;
    localparam ctrlT CW_R_ALU  = ctrlT'((12'd1 << CB_REG_WRITE) | (12'd1 << CB_REG_DST));
    localparam ctrlT CW_SHIFT  = CW_R_ALU | ctrlT'(12'd1 << CB_ALU_SRC_A);
    localparam ctrlT CW_HILO   = ctrlT'(12'd1 << CB_HILO_WRITE);
    localparam ctrlT CW_MULDIV = CW_HILO | CW_R_ALU;
    localparam ctrlT CW_JR     = ctrlT'((12'd1 << CB_JR) | (12'd1 << CB_JUMP));
    localparam ctrlT CW_JALR   = CW_R_ALU | ctrlT'(12'd1 << CB_JR);
    localparam ctrlT CW_IMM    = ctrlT'((12'd1 << CB_REG_WRITE) | (12'd1 << CB_ALU_SRC_B));
    localparam ctrlT CW_LOAD   = CW_IMM | ctrlT'(12'd1 << CB_MEM_TO_REG);
    localparam ctrlT CW_STORE  = ctrlT'((12'd1 << CB_ALU_SRC_B) | (12'd1 << CB_MEM_WRITE) |
                                        (12'd1 << CB_MEM_TO_REG));
    localparam ctrlT CW_BRANCH = ctrlT'(12'd1 << CB_BRANCH);
    localparam ctrlT CW_BAL    = CW_BRANCH |
                                 ctrlT'((12'd1 << CB_BAL) | (12'd1 << CB_REG_WRITE));
    localparam ctrlT CW_J      = ctrlT'(12'd1 << CB_JUMP);
    localparam ctrlT CW_JAL    = ctrlT'((12'd1 << CB_JAL) | (12'd1 << CB_REG_WRITE));

    opT    op;
    functT funct;
    regT   rt;

    assign op    = dec.instr[31:26];
    assign funct = dec.instr[5:0];
    assign rt    = dec.instr[20:16];

    always_comb begin
        dec.ctrl = CW_NONE;
        case (op)
            OP_R_TYPE: begin
                case (funct)
                    FUN_SLL, FUN_SRL, FUN_SRA: dec.ctrl = CW_SHIFT; // shamt on srcA
                    FUN_JR:                    dec.ctrl = CW_JR;
                    FUN_JALR:                  dec.ctrl = CW_JALR;
                    FUN_MTHI, FUN_MTLO:        dec.ctrl = CW_HILO;
                    FUN_MULT, FUN_MULTU,
                    FUN_DIV, FUN_DIVU:         dec.ctrl = CW_MULDIV;
                    default:                   dec.ctrl = CW_R_ALU;
                endcase
            end
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: dec.ctrl = CW_LOAD;
            OP_SB, OP_SH, OP_SW:                dec.ctrl = CW_STORE;
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI:   dec.ctrl = CW_IMM;
            OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ:   dec.ctrl = CW_BRANCH;
            OP_REGIMM: begin
                // selected by rt, not funct
                case (rt)
                    RT_BGEZ, RT_BLTZ:     dec.ctrl = CW_BRANCH;
                    RT_BGEZAL, RT_BLTZAL: dec.ctrl = CW_BAL;
                    default:              dec.ctrl = CW_NONE;
                endcase
            end
            OP_J:    dec.ctrl = CW_J;
            OP_JAL:  dec.ctrl = CW_JAL;
            default: dec.ctrl = CW_NONE;
        endcase
    end

    // data memory access in decode
    always_comb begin
        case (op)
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW,
            OP_SB, OP_SH, OP_SW: dec.memEn = 1'b1;
            default:             dec.memEn = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/mipsPkg.sv */
`default_nettype none

package mipsPkg;

    typedef logic [31:0] instrT;
    typedef logic [5:0]  opT;
    typedef logic [5:0]  functT;
    typedef logic [4:0]  regT;
    typedef logic [11:0] ctrlT;
    typedef logic [3:0]  aluCtrlT;

    // control word bit positions
    localparam int CB_HILO_WRITE = 11;
    localparam int CB_BAL        = 10;
    localparam int CB_JR         = 9;
    localparam int CB_JAL        = 8;
    localparam int CB_ALU_SRC_A  = 7;
    localparam int CB_REG_WRITE  = 6;
    localparam int CB_REG_DST    = 5;
    localparam int CB_ALU_SRC_B  = 4;
    localparam int CB_BRANCH     = 3;
    localparam int CB_MEM_WRITE  = 2;
    localparam int CB_MEM_TO_REG = 1;
    localparam int CB_JUMP       = 0;

    localparam opT OP_R_TYPE = 6'b000000;
    localparam opT OP_REGIMM = 6'b000001; // bltz, bgez and the linking forms
    localparam opT OP_J      = 6'b000010;
    localparam opT OP_JAL    = 6'b000011;
    localparam opT OP_BEQ    = 6'b000100;
    localparam opT OP_BNE    = 6'b000101;
    localparam opT OP_BLEZ   = 6'b000110;
    localparam opT OP_BGTZ   = 6'b000111;
    localparam opT OP_ADDI   = 6'b001000;
    localparam opT OP_ADDIU  = 6'b001001;
    localparam opT OP_SLTI   = 6'b001010;
    localparam opT OP_SLTIU  = 6'b001011;
    localparam opT OP_ANDI   = 6'b001100;
    localparam opT OP_ORI    = 6'b001101;
    localparam opT OP_XORI   = 6'b001110;
    localparam opT OP_LUI    = 6'b001111;
    localparam opT OP_LB     = 6'b100000;
    localparam opT OP_LH     = 6'b100001;
    localparam opT OP_LW     = 6'b100011;
    localparam opT OP_LBU    = 6'b100100;
    localparam opT OP_LHU    = 6'b100101;
    localparam opT OP_SB     = 6'b101000;
    localparam opT OP_SH     = 6'b101001;
    localparam opT OP_SW     = 6'b101011;

    localparam functT FUN_SLL   = 6'b000000;
    localparam functT FUN_SRL   = 6'b000010;
    localparam functT FUN_SRA   = 6'b000011;
    localparam functT FUN_SLLV  = 6'b000100;
    localparam functT FUN_SRLV  = 6'b000110;
    localparam functT FUN_SRAV  = 6'b000111;
    localparam functT FUN_JR    = 6'b001000;
    localparam functT FUN_JALR  = 6'b001001;
    localparam functT FUN_MTHI  = 6'b010001;
    localparam functT FUN_MTLO  = 6'b010011;
    localparam functT FUN_MULT  = 6'b011000;
    localparam functT FUN_MULTU = 6'b011001;
    localparam functT FUN_DIV   = 6'b011010;
    localparam functT FUN_DIVU  = 6'b011011;
    localparam functT FUN_ADD   = 6'b100000;
    localparam functT FUN_ADDU  = 6'b100001;
    localparam functT FUN_SUB   = 6'b100010;
    localparam functT FUN_SUBU  = 6'b100011;
    localparam functT FUN_AND   = 6'b100100;
    localparam functT FUN_OR    = 6'b100101;
    localparam functT FUN_XOR   = 6'b100110;
    localparam functT FUN_NOR   = 6'b100111;
    localparam functT FUN_SLT   = 6'b101010;
    localparam functT FUN_SLTU  = 6'b101011;

    localparam regT RT_BLTZ   = 5'b00000;
    localparam regT RT_BGEZ   = 5'b00001;
    localparam regT RT_BLTZAL = 5'b10000;
    localparam regT RT_BGEZAL = 5'b10001;

    localparam aluCtrlT ALU_ADD  = 4'd0;
    localparam aluCtrlT ALU_SUB  = 4'd1;
    localparam aluCtrlT ALU_AND  = 4'd2;
    localparam aluCtrlT ALU_OR   = 4'd3;
    localparam aluCtrlT ALU_XOR  = 4'd4;
    localparam aluCtrlT ALU_NOR  = 4'd5;
    localparam aluCtrlT ALU_SLT  = 4'd6;
    localparam aluCtrlT ALU_SLTU = 4'd7;
    localparam aluCtrlT ALU_SLL  = 4'd8;
    localparam aluCtrlT ALU_SRL  = 4'd9;
    localparam aluCtrlT ALU_SRA  = 4'd10;
    localparam aluCtrlT ALU_LUI  = 4'd11;
    localparam aluCtrlT ALU_NOP  = 4'd15; // no alu result needed

endpackage

`default_nettype wire

/* runSim.sh */
#!/bin/sh
# build and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module controlUnitTb -f filelist.f -o simControlUnit
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/simControlUnit 2>&1)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Verification passed"; then
    exit 0
else
    echo "pass message not found"
    exit 1
fi

/* tb/controlUnitTb.sv */
`timescale 1ns/1ps
`default_nettype none

module controlUnitTb;
    import mipsPkg::*;

    typedef struct packed {
        instrT   instr;
        ctrlT    ctrl;
        aluCtrlT alu;
        logic    memEn;
        logic    flush;
        logic    stall;
    } entryT;

    // strobes each stage exposes at the top level
    localparam ctrlT E_MASK = 12'h7F2;
    localparam ctrlT M_MASK = 12'h846;
    localparam ctrlT W_MASK = 12'h742;
    localparam int RESET_CYCLES = 16;

    logic clk, rstN, flushE, stallE;
    instrT instrD;
    logic regWriteE, regWriteM, regWriteW, regDstE, aluSrcAE, aluSrcBE, memWriteM;
    logic memToRegE, memToRegM, memToRegW, hiloWriteM, branchD, jumpD, balD, balE, balW;
    logic jalD, jalE, jalW, jrD, jrE, jrW, memEnD;
    aluCtrlT aluCtrlE;

    entryT   tbl[$];
    entryT   cur;
    ctrlT    mE, mM, mW; // reference stage words
    aluCtrlT mAluE;
    integer  seed;
    int      cycles = 0;
    int      limit = 0;

    controlUnit i_controlUnit (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reference pipeline, fed from the table only
    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mE <= '0;
            mAluE <= '0;
            mM <= '0;
            mW <= '0;
        end else begin
            if (cur.flush) begin
                mE <= '0;
                mAluE <= '0;
            end else if (!cur.stall) begin
                mE <= cur.ctrl;
                mAluE <= cur.alu;
            end
            mM <= mE;
            mW <= mM;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("simulation timed out after %0d cycles", cycles);
            stopRun();
        end
    end

    task automatic stopRun();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic checkCtrl(string name, ctrlT exp, ctrlT act);
        if (exp !== act) begin
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
            stopRun();
        end
    endtask

    task automatic checkAlu(string name, aluCtrlT exp, aluCtrlT act);
        if (exp !== act) begin
            $display("[ERROR] %0t %s expected %0d got %0d", $time, name, exp, act);
            stopRun();
        end
    endtask

    task automatic checkBit(string name, logic exp, logic act);
        if (exp !== act) begin
            $display("[ERROR] %0t %s expected %b got %b", $time, name, exp, act);
            stopRun();
        end
    endtask

    function automatic ctrlT packE();
        ctrlT w;
        w = '0;
        w[CB_REG_WRITE] = regWriteE;
        w[CB_REG_DST] = regDstE;
        w[CB_ALU_SRC_A] = aluSrcAE;
        w[CB_ALU_SRC_B] = aluSrcBE;
        w[CB_MEM_TO_REG] = memToRegE;
        w[CB_BAL] = balE;
        w[CB_JAL] = jalE;
        w[CB_JR] = jrE;
        return w;
    endfunction

    function automatic ctrlT packM();
        ctrlT w;
        w = '0;
        w[CB_REG_WRITE] = regWriteM;
        w[CB_MEM_WRITE] = memWriteM;
        w[CB_MEM_TO_REG] = memToRegM;
        w[CB_HILO_WRITE] = hiloWriteM;
        return w;
    endfunction

    function automatic ctrlT packW();
        ctrlT w;
        w = '0;
        w[CB_REG_WRITE] = regWriteW;
        w[CB_MEM_TO_REG] = memToRegW;
        w[CB_BAL] = balW;
        w[CB_JAL] = jalW;
        w[CB_JR] = jrW;
        return w;
    endfunction

    // random rs, rt, rd, shamt around a fixed funct
    function automatic instrT rTypeWord(functT fn);
        logic [31:0] r;
        r = $random(seed);
        return {OP_R_TYPE, r[25:6], fn};
    endfunction

    function automatic instrT opWord(opT op);
        logic [31:0] r;
        r = $random(seed);
        return {op, r[25:0]};
    endfunction

    function automatic instrT regimmWord(regT rtSel);
        logic [31:0] r;
        r = $random(seed);
        return {OP_REGIMM, r[25:21], rtSel, r[15:0]};
    endfunction

    task automatic addEntry(instrT i, ctrlT c, aluCtrlT a, logic m, logic f, logic s);
        tbl.push_back({i, c, a, m, f, s});
    endtask

    task automatic checkStages();
        checkCtrl("ctrlE", mE & E_MASK, packE());
        checkAlu("aluCtrlE", mAluE, aluCtrlE);
        checkCtrl("ctrlM", mM & M_MASK, packM());
        checkCtrl("ctrlW", mW & W_MASK, packW());
    endtask

    task automatic checkDecode();
        checkBit("branchD", cur.ctrl[CB_BRANCH], branchD);
        checkBit("jumpD", cur.ctrl[CB_JUMP], jumpD);
        checkBit("balD", cur.ctrl[CB_BAL], balD);
        checkBit("jalD", cur.ctrl[CB_JAL], jalD);
        checkBit("jrD", cur.ctrl[CB_JR], jrD);
        checkBit("memEnD", cur.memEn, memEnD);
    endtask

    task automatic checkIdle();
        checkCtrl("ctrlE", '0, packE());
        checkAlu("aluCtrlE", '0, aluCtrlE);
        checkCtrl("ctrlM", '0, packM());
        checkCtrl("ctrlW", '0, packW());
    endtask

    task automatic applyEntry(entryT e);
        cur = e;
        instrD = e.instr;
        flushE = e.flush;
        stallE = e.stall;
    endtask

    initial begin
        seed = 92263;
        addEntry(opWord(OP_ADDI), 12'h050, ALU_ADD, 1'b0, 1'b0, 1'b0);
        addEntry(opWord(OP_SLTIU), 12'h050, ALU_SLTU, 1'b0, 1'b0, 1'b0);
        addEntry(opWord(OP_ORI), 12'h050, ALU_OR, 1'b0, 1'b1, 1'b0); // bubble
        addEntry(opWord(OP_ANDI), 12'h050, ALU_AND, 1'b0, 1'b0, 1'b0);
        addEntry(opWord(OP_LUI), 12'h050, ALU_LUI, 1'b0, 1'b0, 1'b0);
        addEntry(opWord(OP_LB), 12'h052, ALU_ADD, 1'b1, 1'b0, 1'b0);
        addEntry(opWord(OP_LH), 12'h052, ALU_ADD, 1'b1, 1'b0, 1'b0);
        addEntry(opWord(OP_LW), 12'h052, ALU_ADD, 1'b1, 1'b0, 1'b0);
        addEntry(opWord(OP_LBU), 12'h052, ALU_ADD, 1'b1, 1'b0, 1'b0);
        addEntry(opWord(OP_LHU), 12'h052, ALU_ADD, 1'b1, 1'b0, 1'b0);
        addEntry(opWord(OP_SB), 12'h016, ALU_ADD, 1'b1, 1'b0, 1'b0);
        addEntry(opWord(OP_SH), 12'h016, ALU_ADD, 1'b1, 1'b0, 1'b0);
        addEntry(opWord(OP_SW), 12'h016, ALU_ADD, 1'b1, 1'b0, 1'b0);
        addEntry(rTypeWord(FUN_ADD), 12'h060, ALU_ADD, 1'b0, 1'b0, 1'b0);
        addEntry(rTypeWord(FUN_SUB), 12'h060, ALU_SUB, 1'b0, 1'b0, 1'b1); // E holds ADD
        addEntry(rTypeWord(FUN_AND), 12'h060, ALU_AND, 1'b0, 1'b0, 1'b1);
        addEntry(rTypeWord(FUN_OR), 12'h060, ALU_OR, 1'b0, 1'b0, 1'b0);
        addEntry(rTypeWord(FUN_XOR), 12'h060, ALU_XOR, 1'b0, 1'b0, 1'b0);
        addEntry(rTypeWord(FUN_NOR), 12'h060, ALU_NOR, 1'b0, 1'b0, 1'b0);
        addEntry(rTypeWord(FUN_SLT), 12'h060, ALU_SLT, 1'b0, 1'b0, 1'b0);
        addEntry(rTypeWord(FUN_SLTU), 12'h060, ALU_SLTU, 1'b0, 1'b0, 1'b0);
        addEntry(rTypeWord(FUN_SLL), 12'h0E0, ALU_SLL, 1'b0, 1'b0, 1'b0);
        addEntry(rTypeWord(FUN_SRA), 12'h0E0, ALU_SRA, 1'b0, 1'b0, 1'b0);
        addEntry(rTypeWord(FUN_SRLV), 12'h060, ALU_SRL, 1'b0, 1'b0, 1'b0);
        addEntry(rTypeWord(FUN_MULT), 12'h860, ALU_NOP, 1'b0, 1'b1, 1'b1); // flush over stall
        addEntry(rTypeWord(FUN_DIVU), 12'h860, ALU_NOP, 1'b0, 1'b0, 1'b0);
        addEntry(rTypeWord(FUN_MTHI), 12'h800, ALU_NOP, 1'b0, 1'b0, 1'b0);
        addEntry(opWord(OP_BEQ), 12'h008, ALU_SUB, 1'b0, 1'b0, 1'b0);
        addEntry(opWord(OP_BGTZ), 12'h008, ALU_SUB, 1'b0, 1'b0, 1'b0);
        addEntry(regimmWord(RT_BLTZ), 12'h008, ALU_SUB, 1'b0, 1'b0, 1'b0);
        addEntry(regimmWord(RT_BGEZ), 12'h008, ALU_SUB, 1'b0, 1'b0, 1'b0);
        addEntry(regimmWord(RT_BLTZAL), 12'h448, ALU_SUB, 1'b0, 1'b0, 1'b0);
        addEntry(regimmWord(RT_BGEZAL), 12'h448, ALU_SUB, 1'b0, 1'b0, 1'b0);
        addEntry(opWord(OP_J), 12'h001, ALU_NOP, 1'b0, 1'b0, 1'b0);
        addEntry(opWord(OP_JAL), 12'h140, ALU_NOP, 1'b0, 1'b0, 1'b0);
        addEntry(rTypeWord(FUN_JR), 12'h201, ALU_NOP, 1'b0, 1'b0, 1'b0);
        addEntry(rTypeWord(FUN_JALR), 12'h260, ALU_NOP, 1'b0, 1'b0, 1'b0);
        addEntry(opWord(6'b111111), 12'h000, ALU_NOP, 1'b0, 1'b0, 1'b0);
        addEntry(regimmWord(5'b00011), 12'h000, ALU_NOP, 1'b0, 1'b0, 1'b0);
        addEntry(rTypeWord(6'b111111), 12'h060, ALU_NOP, 1'b0, 1'b0, 1'b0);
        // drain the last ones to writeback
        repeat (3) addEntry(rTypeWord(FUN_SLL), 12'h0E0, ALU_SLL, 1'b0, 1'b0, 1'b0);
        limit = tbl.size() + RESET_CYCLES + 40;

        rstN = 1'b0;
        applyEntry({32'h0, 12'h0E0, ALU_SLL, 1'b0, 1'b0, 1'b0}); // sll, kept out by reset only
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            checkIdle();
        end
        rstN = 1'b1;

        foreach (tbl[i]) begin
            applyEntry(tbl[i]);
            @(negedge clk);
            checkDecode();
            checkStages();
        end

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire
